//--- vz_pkg.sv
package vz_pkg;

	typedef logic [15:0] addr_t;
	typedef logic [7:0]  data_t;
	typedef logic [63:0] key_matrix_t;	// Row*8+column, 1 = released
	typedef logic [6:0]  key_ext_t;	// RShift Esc Up Left Right Down BkSp from bit 0
	typedef logic [5:0]  joy_t;	// Arm fire right left down up, 1 = pressed

	typedef enum logic [1:0] {REG_NONE, REG_IO, REG_VRAM, REG_RAM} region_e;

	// Scan code lookup result
	typedef struct packed {
		logic       hit;
		logic       ext;
		logic [5:0] idx;
	} key_sel_t;

	localparam int VRAM_AW = 11;
	localparam int RAM_AW  = 14;
	localparam data_t OPEN_BUS = 8'hFF;

	localparam addr_t IO_BASE   = 16'h6800;
	localparam addr_t VRAM_BASE = 16'h7000;
	localparam addr_t RAM_BASE  = 16'h7800;
	localparam addr_t RAM_LAST  = 16'hB7FF;
	localparam logic [3:0] JOY_PORT_HI = 4'h2;	// I/O ports 0x20-0x2F

	// PS/2 set 2 codes by matrix position, 0x00 marks an empty slot
	localparam data_t MATRIX_SCAN [64] = '{
		8'h2C, 8'h1D, 8'h00, 8'h24, 8'h15, 8'h2D, 8'h00, 8'h00,	// T W . E Q R
		8'h34, 8'h1B, 8'h14, 8'h23, 8'h1C, 8'h2B, 8'h00, 8'h00,	// G S Ctrl D A F
		8'h32, 8'h22, 8'h12, 8'h21, 8'h1A, 8'h2A, 8'h00, 8'h00,	// B X Shift C Z V
		8'h2E, 8'h1E, 8'h00, 8'h26, 8'h16, 8'h25, 8'h00, 8'h00,	// 5 2 . 3 1 4
		8'h31, 8'h49, 8'h00, 8'h41, 8'h29, 8'h3A, 8'h00, 8'h00,	// N period . comma Space M
		8'h36, 8'h46, 8'h4E, 8'h3E, 8'h45, 8'h3D, 8'h00, 8'h00,	// 6 9 minus 8 0 7
		8'h35, 8'h44, 8'h5A, 8'h43, 8'h4D, 8'h3C, 8'h00, 8'h00,	// Y O Return I P U
		8'h33, 8'h4B, 8'h52, 8'h42, 8'h4C, 8'h3B, 8'h00, 8'h00	// H L colon K semicolon J
	};

	// Same order as key_ext_t
	localparam data_t EXT_SCAN [7] = '{8'h59, 8'h76, 8'h75, 8'h6B, 8'h74, 8'h72, 8'h66};

	function automatic region_e decode_region(input addr_t addr, input logic io);
		if (io)
			return REG_NONE;	// Port space never hits memory
		if (addr >= IO_BASE && addr < VRAM_BASE)
			return REG_IO;
		if (addr >= VRAM_BASE && addr < RAM_BASE)
			return REG_VRAM;
		if (addr >= RAM_BASE && addr <= RAM_LAST)
			return REG_RAM;
		return REG_NONE;
	endfunction

	function automatic key_sel_t scan_to_key(input data_t code);
		key_sel_t sel;
		sel = '0;
		for (int i = 0; i < 64; i++)
		begin
			if (code != 8'h00 && MATRIX_SCAN[i] == code)
			begin
				sel.hit = 1'b1;
				sel.ext = 1'b0;
				sel.idx = 6'(i);
			end
		end
		for (int i = 0; i < 7; i++)
		begin
			if (EXT_SCAN[i] == code)
			begin
				sel.hit = 1'b1;
				sel.ext = 1'b1;
				sel.idx = 6'(i);
			end
		end
		return sel;
	endfunction

endpackage

//--- vz_ram.sv
`timescale 1ns/1ps

module vz_ram #(
	parameter int ADDR_W = 11
) (
	input  logic                CLK50MHZ,
	input  logic [ADDR_W-1:0]   addr_i,
	input  logic                we_i,
	input  vz_pkg::data_t       wdata_i,
	output vz_pkg::data_t       rdata_o
);

	vz_pkg::data_t mem [2**ADDR_W];

	// Read-before-write, data one cycle after the address
	always_ff @(posedge CLK50MHZ)
	begin
		if (we_i)
			mem[addr_i] <= wdata_i;
		rdata_o <= mem[addr_i];
	end

endmodule

//--- vz_bus_ctrl.sv
`timescale 1ns/1ps

module vz_bus_ctrl (
	input  logic            CLK50MHZ,
	input  logic            RESET_N,
	input  logic            req_i,
	input  logic            io_i,
	input  logic            wr_i,
	input  vz_pkg::addr_t   addr_i,
	input  vz_pkg::data_t   wdata_i,
	output logic            ack_o,
	output vz_pkg::data_t   rdata_o,
	output vz_pkg::addr_t   mem_addr_o,
	output vz_pkg::data_t   mem_wdata_o,
	output logic            ram_we_o,
	output logic            vram_we_o,
	output logic            latch_we_o,
	input  vz_pkg::data_t   ram_rdata_i,
	input  vz_pkg::data_t   vram_rdata_i,
	input  vz_pkg::data_t   kbd_rdata_i,
	input  vz_pkg::data_t   joy_rdata_i
);

	typedef enum logic [1:0] {IDLE, ACCESS, CAPTURE, ACK} state_e;

	state_e           state;
	logic             io_q;
	logic             wr_q;
	vz_pkg::addr_t    addr_q;
	vz_pkg::data_t    wdata_q;
	vz_pkg::region_e  region;
	logic             wr_cycle;
	vz_pkg::data_t    rd_sel;

	// Request copy held for the whole transfer
	always_ff @(posedge CLK50MHZ)
	begin
		if (state == IDLE && req_i)
		begin
			io_q    <= io_i;
			wr_q    <= wr_i;
			addr_q  <= addr_i;
			wdata_q <= wdata_i;
		end
	end

	assign region = vz_pkg::decode_region(addr_q, io_q);
	assign wr_cycle = (state == ACCESS) && wr_q;	// Single cycle after sampling

	assign ram_we_o    = wr_cycle && (region == vz_pkg::REG_RAM);
	assign vram_we_o   = wr_cycle && (region == vz_pkg::REG_VRAM);
	assign latch_we_o  = wr_cycle && (region == vz_pkg::REG_IO);
	assign mem_addr_o  = addr_q;
	assign mem_wdata_o = wdata_q;

	always_comb
	begin
		rd_sel = vz_pkg::OPEN_BUS;
		if (!wr_q)
		begin
			if (io_q)
			begin
				if (addr_q[7:4] == vz_pkg::JOY_PORT_HI)
					rd_sel = joy_rdata_i;
			end
			else
			begin
				case (region)
					vz_pkg::REG_RAM:  rd_sel = ram_rdata_i;
					vz_pkg::REG_VRAM: rd_sel = vram_rdata_i;
					vz_pkg::REG_IO:   rd_sel = kbd_rdata_i;	// Keyboard rows
					default:          rd_sel = vz_pkg::OPEN_BUS;
				endcase
			end
		end
	end

	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			state   <= IDLE;
			ack_o   <= 1'b0;
			rdata_o <= vz_pkg::OPEN_BUS;
		end
		else
		begin
			ack_o <= (state == ACK);	// Trails the state by one cycle
			case (state)
				IDLE:
					if (req_i)
						state <= ACCESS;
				ACCESS:
					state <= CAPTURE;	// RAM read data lands here
				CAPTURE:
				begin
					rdata_o <= rd_sel;
					state   <= ACK;
				end
				ACK:
					if (!req_i)
						state <= IDLE;
				default:
					state <= IDLE;
			endcase
		end
	end

endmodule

//--- vz_keyboard.sv
`timescale 1ns/1ps

module vz_keyboard (
	input  logic            CLK50MHZ,
	input  logic            RESET_N,
	input  logic            key_strobe_i,
	input  logic            key_pressed_i,
	input  vz_pkg::data_t   key_code_i,
	input  logic            cass_in_i,
	input  vz_pkg::data_t   row_sel_i,
	output vz_pkg::data_t   kbd_rdata_o
);

	vz_pkg::key_matrix_t  key_q;
	vz_pkg::key_ext_t     ext_q;
	vz_pkg::key_sel_t     sel;
	vz_pkg::key_matrix_t  eff;
	logic                 col;

	assign sel = vz_pkg::scan_to_key(key_code_i);

	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			key_q <= '1;	// All released
			ext_q <= '1;
		end
		else if (key_strobe_i && sel.hit)
		begin
			if (sel.ext)
				ext_q[sel.idx[2:0]] <= ~key_pressed_i;
			else
				key_q[sel.idx] <= ~key_pressed_i;
		end
	end

	// Extended keys fold onto Ctrl plus a matrix key
	always_comb
	begin
		eff = key_q;
		eff[37] = key_q[37] & ext_q[3] & ext_q[6];	// Left, backspace as M
		eff[36] = key_q[36] & ext_q[5];	// Down as space
		eff[35] = key_q[35] & ext_q[4];	// Right as comma
		eff[33] = key_q[33] & ext_q[2];	// Up as period
		eff[42] = key_q[42] & ext_q[1];	// Esc as minus
		eff[18] = key_q[18] & ext_q[0];	// Right shift, no Ctrl
		eff[10] = key_q[10] & (&ext_q[6:1]);
	end

	// A column reads low if any selected row has it pressed
	always_comb
	begin
		kbd_rdata_o[7] = 1'b1;
		kbd_rdata_o[6] = ~cass_in_i;
		for (int j = 0; j < 6; j++)
		begin
			col = 1'b1;
			for (int r = 0; r < 8; r++)
			begin
				if (!row_sel_i[r] && !eff[r*8+j])
					col = 1'b0;
			end
			kbd_rdata_o[j] = col;
		end
	end

endmodule

//--- vz_io_port.sv
`timescale 1ns/1ps

module vz_io_port (
	input  logic            CLK50MHZ,
	input  logic            RESET_N,
	input  logic            latch_we_i,
	input  vz_pkg::data_t   wdata_i,
	input  logic [3:0]      addr_low_i,
	input  vz_pkg::joy_t    joy1_i,
	input  vz_pkg::joy_t    joy2_i,
	output vz_pkg::data_t   joy_rdata_o,
	output logic [1:0]      spk_o,
	output logic            cass_out_o,
	output logic            vdg_ag_o,
	output logic            vdg_css_o
);

	vz_pkg::data_t joy1_dir;
	vz_pkg::data_t joy1_arm;
	vz_pkg::data_t joy2_dir;
	vz_pkg::data_t joy2_arm;

	// Output latch, only the used bits are kept
	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			spk_o      <= 2'b00;
			cass_out_o <= 1'b0;
			vdg_ag_o   <= 1'b0;
			vdg_css_o  <= 1'b0;
		end
		else if (latch_we_i)
		begin
			spk_o      <= {wdata_i[0], wdata_i[5]};	// Speaker pair
			cass_out_o <= wdata_i[2];
			vdg_ag_o   <= wdata_i[3];	// Graphics mode
			vdg_css_o  <= wdata_i[4];	// Colour set
		end
	end

	// Active low source bytes
	assign joy1_dir = {3'b111, ~joy1_i[4:0]};
	assign joy1_arm = {3'b111, ~joy1_i[5], 4'b1111};
	assign joy2_dir = {3'b111, ~joy2_i[4:0]};
	assign joy2_arm = {3'b111, ~joy2_i[5], 4'b1111};

	// Each low address bit enables one source
	assign joy_rdata_o = (addr_low_i[0] ? 8'hFF : joy1_dir) &
		(addr_low_i[1] ? 8'hFF : joy1_arm) &
		(addr_low_i[2] ? 8'hFF : joy2_dir) &
		(addr_low_i[3] ? 8'hFF : joy2_arm);

endmodule

//--- vz_top.sv
`timescale 1ns/1ps

module vz_top (
	input  logic            CLK50MHZ,
	input  logic            RESET_N,
	input  logic            req_i,
	input  logic            io_i,
	input  logic            wr_i,
	input  vz_pkg::addr_t   addr_i,
	input  vz_pkg::data_t   wdata_i,
	output logic            ack_o,
	output vz_pkg::data_t   rdata_o,
	input  logic            key_strobe_i,
	input  logic            key_pressed_i,
	input  vz_pkg::data_t   key_code_i,
	input  logic            cass_in_i,
	input  vz_pkg::joy_t    joy1_i,
	input  vz_pkg::joy_t    joy2_i,
	output logic [1:0]      spk_o,
	output logic            cass_out_o,
	output logic            vdg_ag_o,
	output logic            vdg_css_o
);

	vz_pkg::addr_t  mem_addr;
	vz_pkg::data_t  mem_wdata;
	logic           ram_we;
	logic           vram_we;
	logic           latch_we;
	vz_pkg::data_t  ram_rdata;
	vz_pkg::data_t  vram_rdata;
	vz_pkg::data_t  kbd_rdata;
	vz_pkg::data_t  joy_rdata;

	vz_bus_ctrl i_bus_ctrl (
		.CLK50MHZ     (CLK50MHZ),
		.RESET_N      (RESET_N),
		.req_i        (req_i),
		.io_i         (io_i),
		.wr_i         (wr_i),
		.addr_i       (addr_i),
		.wdata_i      (wdata_i),
		.ack_o        (ack_o),
		.rdata_o      (rdata_o),
		.mem_addr_o   (mem_addr),
		.mem_wdata_o  (mem_wdata),
		.ram_we_o     (ram_we),
		.vram_we_o    (vram_we),
		.latch_we_o   (latch_we),
		.ram_rdata_i  (ram_rdata),
		.vram_rdata_i (vram_rdata),
		.kbd_rdata_i  (kbd_rdata),
		.joy_rdata_i  (joy_rdata)
	);

	// 16 KB user RAM, 0x7800-0xB7FF folds onto 14 bits
	vz_ram #(
		.ADDR_W (vz_pkg::RAM_AW)
	) i_ram (
		.CLK50MHZ (CLK50MHZ),
		.addr_i   (mem_addr[vz_pkg::RAM_AW-1:0]),
		.we_i     (ram_we),
		.wdata_i  (mem_wdata),
		.rdata_o  (ram_rdata)
	);

	vz_ram #(
		.ADDR_W (vz_pkg::VRAM_AW)
	) i_vram (
		.CLK50MHZ (CLK50MHZ),
		.addr_i   (mem_addr[vz_pkg::VRAM_AW-1:0]),
		.we_i     (vram_we),
		.wdata_i  (mem_wdata),
		.rdata_o  (vram_rdata)
	);

	vz_keyboard i_keyboard (
		.CLK50MHZ      (CLK50MHZ),
		.RESET_N       (RESET_N),
		.key_strobe_i  (key_strobe_i),
		.key_pressed_i (key_pressed_i),
		.key_code_i    (key_code_i),
		.cass_in_i     (cass_in_i),
		.row_sel_i     (mem_addr[7:0]),	// Row select on A7..A0
		.kbd_rdata_o   (kbd_rdata)
	);

	vz_io_port i_io_port (
		.CLK50MHZ    (CLK50MHZ),
		.RESET_N     (RESET_N),
		.latch_we_i  (latch_we),
		.wdata_i     (mem_wdata),
		.addr_low_i  (mem_addr[3:0]),
		.joy1_i      (joy1_i),
		.joy2_i      (joy2_i),
		.joy_rdata_o (joy_rdata),
		.spk_o       (spk_o),
		.cass_out_o  (cass_out_o),
		.vdg_ag_o    (vdg_ag_o),
		.vdg_css_o   (vdg_css_o)
	);

endmodule

//--- vz_tb_clk.sv
`timescale 1ns/1ps

module vz_tb_clk (
	output logic CLK50MHZ,
	output logic RESET_N
);

	// 50 MHz, 20 ns period
	initial
	begin
		CLK50MHZ = 1'b0;
		forever #10 CLK50MHZ = ~CLK50MHZ;
	end

	initial
	begin
		RESET_N = 1'b0;
		repeat (4) @(negedge CLK50MHZ);	// Released away from the rising edge
		RESET_N = 1'b1;
	end

endmodule

//--- vz_properties.sv
`timescale 1ns/1ps

module vz_properties (
	input logic CLK50MHZ,
	input logic RESET_N,
	input logic req_i,
	input logic ack_o,
	input logic ram_we_o,
	input logic vram_we_o,
	input logic latch_we_o
);

	logic any_we;
	logic failed = 1'b0;	// Sticky, set by any failed property

	assign any_we = ram_we_o | vram_we_o | latch_we_o;

	// Ack only answers a request
	ack_needs_req: assert property (@(posedge CLK50MHZ) disable iff (!RESET_N)
		$rose(ack_o) |-> $past(req_i))
		else
		begin
			$error("ack_o rose while req_i was low");
			failed = 1'b1;
		end

	ack_falls_late: assert property (@(posedge CLK50MHZ) disable iff (!RESET_N)
		$fell(ack_o) |-> !$past(req_i))
		else
		begin
			$error("ack_o fell while req_i was still high");
			failed = 1'b1;
		end

	// Write strobes are exclusive and single cycle
	strobe_onehot: assert property (@(posedge CLK50MHZ) disable iff (!RESET_N)
		$onehot0({ram_we_o, vram_we_o, latch_we_o}))
		else
		begin
			$error("more than one write strobe high");
			failed = 1'b1;
		end

	strobe_single: assert property (@(posedge CLK50MHZ) disable iff (!RESET_N)
		any_we |=> !any_we)
		else
		begin
			$error("write strobe held longer than one cycle");
			failed = 1'b1;
		end

endmodule

//--- vz_tb.sv
`timescale 1ns/1ps

module vz_tb;

	logic             CLK50MHZ;
	logic             RESET_N;
	logic             req_i;
	logic             io_i;
	logic             wr_i;
	vz_pkg::addr_t    addr_i;
	vz_pkg::data_t    wdata_i;
	logic             ack_o;
	vz_pkg::data_t    rdata_o;
	logic             key_strobe_i;
	logic             key_pressed_i;
	vz_pkg::data_t    key_code_i;
	logic             cass_in_i;
	vz_pkg::joy_t     joy1_i;
	vz_pkg::joy_t     joy2_i;
	logic [1:0]       spk_o;
	logic             cass_out_o;
	logic             vdg_ag_o;
	logic             vdg_css_o;

	vz_pkg::data_t    mem_model [vz_pkg::addr_t];	// Both RAMs by bus address
	bit               key_down [256];
	logic [31:0]      lcg_state = 32'd67;
	vz_pkg::data_t    exp_q [$];
	vz_pkg::data_t    got_q [$];
	vz_pkg::addr_t    at_q [$];
	logic [4:0]       out_exp_q [$];	// spk, cass, ag, css
	logic [4:0]       out_got_q [$];
	vz_pkg::addr_t    addr_log [$];
	vz_pkg::data_t    ext_codes [7] = '{8'h6B, 8'h66, 8'h72, 8'h74, 8'h75, 8'h76, 8'h59};

	vz_tb_clk i_clk (
		.CLK50MHZ (CLK50MHZ),
		.RESET_N  (RESET_N)
	);

	vz_top i_vz_top (.*);

	bind vz_bus_ctrl vz_properties i_vz_properties (.*);

	function automatic logic [15:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:16];	// Upper bits, longer period
	endfunction

	// Matrix positions a scan code presses
	function automatic logic [63:0] key_positions(input vz_pkg::data_t code);
		logic [63:0] m;
		m = '0;
		case (code)
			8'h1C: m[12] = 1'b1;	// A
			8'h15: m[4] = 1'b1;	// Q
			8'h2E: m[24] = 1'b1;	// 5
			8'h3B: m[61] = 1'b1;	// J
			8'h5A: m[50] = 1'b1;	// Return
			8'h6B, 8'h66: m[37] = 1'b1;	// Left, backspace
			8'h72: m[36] = 1'b1;	// Down
			8'h74: m[35] = 1'b1;	// Right
			8'h75: m[33] = 1'b1;	// Up
			8'h76: m[42] = 1'b1;	// Esc
			8'h59: m[18] = 1'b1;	// Right shift
			default: m = '0;
		endcase
		if (code inside {8'h6B, 8'h66, 8'h72, 8'h74, 8'h75, 8'h76})
			m[10] = 1'b1;	// Ctrl
		return m;
	endfunction

	function automatic vz_pkg::data_t ref_read(input logic io, input vz_pkg::addr_t addr);
		vz_pkg::data_t b;
		logic [63:0]   down;
		b = 8'hFF;
		down = '0;
		if (io)
		begin
			if (addr[7:4] == 4'h2)
			begin
				if (!addr[0])
					b[4:0] = b[4:0] & ~joy1_i[4:0];
				if (!addr[1] && joy1_i[5])
					b[4] = 1'b0;
				if (!addr[2])
					b[4:0] = b[4:0] & ~joy2_i[4:0];
				if (!addr[3] && joy2_i[5])
					b[4] = 1'b0;
			end
		end
		else if (addr >= 16'h7000 && addr <= 16'hB7FF)
			b = mem_model[addr];
		else if (addr >= 16'h6800 && addr < 16'h7000)
		begin
			for (int c = 0; c < 256; c++)
				if (key_down[c])
					down = down | key_positions(8'(c));
			b[6] = ~cass_in_i;
			for (int r = 0; r < 8; r++)
				for (int j = 0; j < 6; j++)
					if (!addr[r] && down[r*8+j])
						b[j] = 1'b0;
		end
		return b;
	endfunction

	function automatic logic [4:0] latch_outputs(input vz_pkg::data_t d);
		return {d[0], d[5], d[2], d[3], d[4]};
	endfunction

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic check_data(input vz_pkg::data_t got, input vz_pkg::data_t exp,
		input vz_pkg::addr_t addr);
		if (got !== exp)
			stop_run($sformatf("FAIL %0t: read at %h got %h expected %h",
				$time, addr, got, exp));
	endtask

	task automatic check_outputs(input logic [4:0] got, input logic [4:0] exp);
		if (got !== exp)
			stop_run($sformatf("FAIL %0t: spk/cass/ag/css got %b expected %b",
				$time, got, exp));
	endtask

	// One full four-phase transfer, entered and left on a falling edge
	task automatic bus_xfer(input logic io, input logic wr, input vz_pkg::addr_t addr,
		input vz_pkg::data_t data, output vz_pkg::data_t rd);
		int cyc;
		req_i   = 1'b1;
		io_i    = io;
		wr_i    = wr;
		addr_i  = addr;
		wdata_i = data;
		cyc = 0;
		do
		begin
			@(negedge CLK50MHZ);
			cyc++;
			if (cyc > 16)
				stop_run("Timeout waiting for ack_o to rise");
		end
		while (!ack_o);
		if (cyc != 4)	// First falling edge follows the sampling edge
			stop_run($sformatf("FAIL %0t: ack_o rose %0d cycles after sampling",
				$time, cyc - 1));
		rd = rdata_o;
		req_i = 1'b0;
		cyc = 0;
		do
		begin
			@(negedge CLK50MHZ);
			cyc++;
			if (cyc > 16)
				stop_run("Timeout waiting for ack_o to fall");
		end
		while (ack_o);
	endtask

	task automatic write_mem(input vz_pkg::addr_t addr, input vz_pkg::data_t data);
		vz_pkg::data_t rd;
		bus_xfer(1'b0, 1'b1, addr, data, rd);
		if (addr >= 16'h7000 && addr <= 16'hB7FF)
			mem_model[addr] = data;
	endtask

	task automatic write_latch(input vz_pkg::data_t data);
		vz_pkg::data_t rd;
		bus_xfer(1'b0, 1'b1, 16'h6800 + (lcg_next() & 16'h07FF), data, rd);
		out_exp_q.push_back(latch_outputs(data));
		out_got_q.push_back({spk_o, cass_out_o, vdg_ag_o, vdg_css_o});
	endtask

	task automatic read_check(input logic io, input vz_pkg::addr_t addr);
		vz_pkg::data_t rd;
		bus_xfer(io, 1'b0, addr, 8'h00, rd);
		exp_q.push_back(ref_read(io, addr));
		got_q.push_back(rd);
		at_q.push_back(addr);
	endtask

	task automatic key_event(input vz_pkg::data_t code, input logic down);
		key_strobe_i  = 1'b1;
		key_pressed_i = down;
		key_code_i    = code;
		@(negedge CLK50MHZ);
		key_strobe_i = 1'b0;
		key_down[code] = down;
		@(negedge CLK50MHZ);
	endtask

	// Keyboard byte for all rows, no rows, each single row and a random mask
	task automatic scan_rows();
		read_check(1'b0, 16'h6800);
		read_check(1'b0, 16'h6FFF);
		read_check(1'b0, {8'h6A, 8'(lcg_next())});
		for (int r = 0; r < 8; r++)
			read_check(1'b0, {5'b01101, 3'(lcg_next()), ~(8'h01 << r)});
	endtask

	always @(posedge CLK50MHZ)
	begin
		if (got_q.size() > 0)
			check_data(got_q.pop_front(), exp_q.pop_front(), at_q.pop_front());
		if (out_got_q.size() > 0)
			check_outputs(out_got_q.pop_front(), out_exp_q.pop_front());
		if (i_vz_top.i_bus_ctrl.i_vz_properties.failed === 1'b1)
			stop_run("A bus protocol assertion failed");
	end

	initial
	begin
		int            cyc;
		vz_pkg::addr_t a;
		req_i         = 1'b0;
		io_i          = 1'b0;
		wr_i          = 1'b0;
		addr_i        = '0;
		wdata_i       = '0;
		key_strobe_i  = 1'b0;
		key_pressed_i = 1'b0;
		key_code_i    = '0;
		cass_in_i     = 1'b0;
		joy1_i        = '0;
		joy2_i        = '0;
		cyc = 0;
		while (RESET_N !== 1'b1)
		begin
			@(negedge CLK50MHZ);
			cyc++;
			if (cyc > 10)
				stop_run("Reset was never released");
		end
		@(negedge CLK50MHZ);
		if (ack_o !== 1'b0)
			stop_run($sformatf("FAIL %0t: ack_o is %b after reset", $time, ack_o));
		exp_q.push_back(8'hFF);
		got_q.push_back(rdata_o);
		at_q.push_back(16'h0000);
		out_exp_q.push_back(5'b00000);
		out_got_q.push_back({spk_o, cass_out_o, vdg_ag_o, vdg_css_o});

		// Range ends first, then random addresses in both RAMs
		addr_log = '{16'h7000, 16'h77FF, 16'h7800, 16'hB7FF};
		for (int i = 0; i < 20; i++)
		begin
			if (i[0])
				a = 16'h7800 + (lcg_next() & 16'h3FFF);
			else
				a = 16'h7000 + (lcg_next() & 16'h07FF);
			addr_log.push_back(a);
		end
		foreach (addr_log[i])
			write_mem(addr_log[i], 8'(lcg_next()));
		foreach (addr_log[i])
			read_check(1'b0, addr_log[i]);

		read_check(1'b0, 16'h0000);
		read_check(1'b0, 16'hC000);
		read_check(1'b0, 16'h67FF);
		read_check(1'b0, 16'hFFFF);
		write_mem(16'h0000, 8'h5A);
		write_mem(16'hC000, 8'hA5);	// Aliases 0x7000 on the low bits
		write_mem(16'hB800, 8'h3C);	// Aliases 0x7800
		foreach (addr_log[i])
			read_check(1'b0, addr_log[i]);

		scan_rows();
		key_event(8'h1C, 1'b1);
		key_event(8'h15, 1'b1);
		scan_rows();
		key_event(8'h2E, 1'b1);
		key_event(8'h3B, 1'b1);
		key_event(8'h5A, 1'b1);
		cass_in_i = 1'b1;
		scan_rows();
		key_event(8'h15, 1'b0);
		key_event(8'h2E, 1'b0);
		cass_in_i = 1'b0;
		scan_rows();
		key_event(8'h1C, 1'b0);
		key_event(8'h3B, 1'b0);
		key_event(8'h5A, 1'b0);

		foreach (ext_codes[k])
		begin
			key_event(ext_codes[k], 1'b1);
			scan_rows();
			key_event(ext_codes[k], 1'b0);
		end
		key_event(8'h6B, 1'b1);
		key_event(8'h66, 1'b1);
		key_event(8'h6B, 1'b0);	// Backspace still holds M and Ctrl
		scan_rows();
		key_event(8'h66, 1'b0);
		scan_rows();

		for (int i = 0; i < 6; i++)
			write_latch(8'(lcg_next()));
		for (int i = 0; i < 16; i++)
		begin
			joy1_i = 6'(lcg_next());
			joy2_i = 6'(lcg_next());
			read_check(1'b1, {8'(lcg_next()), 4'h2, 4'(lcg_next())});
		end
		read_check(1'b1, 16'h0010);
		read_check(1'b1, 16'h0030);
		read_check(1'b1, 16'h00FF);
		read_check(1'b1, 16'h6800);

		cyc = 0;
		while (got_q.size() > 0 || out_got_q.size() > 0)
		begin
			@(negedge CLK50MHZ);
			cyc++;
			if (cyc > 10)
				stop_run("Compare queues did not drain");
		end
		if (i_vz_top.i_bus_ctrl.i_vz_properties.failed === 1'b1)
			stop_run("A bus protocol assertion failed");
		else
		begin
			$display("test passed");
			$finish;
		end
	end

endmodule

//--- src.f
vz_pkg.sv
vz_ram.sv
vz_bus_ctrl.sv
vz_keyboard.sv
vz_io_port.sv
vz_top.sv
vz_tb_clk.sv
vz_properties.sv
vz_tb.sv

//--- Bender.yml
package:
  name: vz_memio

sources:
  - files:
      - vz_pkg.sv
      - vz_ram.sv
      - vz_bus_ctrl.sv
      - vz_keyboard.sv
      - vz_io_port.sv
      - vz_top.sv
  - target: test
    files:
      - vz_tb_clk.sv
      - vz_properties.sv
      - vz_tb.sv
